/* rv_core.f */
source/rv_core_pkg.sv
source/core_control.sv
source/instr_decode.sv
source/exec_unit.sv
source/register_file.sv
source/load_store_unit.sv
source/rv_core.sv
tests/rv_core_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
		-Mdir obj_dir -f rv_core.f
	@out="$$(./obj_dir/Vrv_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam logic [31:0] halt_addr = 32'h0000_006c;
    // 28 instructions at up to about 12 cycles each with the longest ready delays
    localparam int cycle_limit = 2000;

    logic        inst_selfdefine = 1'b0;
    logic        reset = 1'b1;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready = 1'b0;
    logic [31:0] fetch_data = 32'h0;
    logic        mem_valid;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ready = 1'b0;
    logic [31:0] mem_rdata = 32'h0;

    logic [31:0] imem [64];
    logic [31:0] dmem [logic [31:0]];
    int unsigned fetch_wait = 0;
    int unsigned mem_wait = 0;
    logic [4:0]  fetch_idx = 5'd0;
    logic [3:0]  store_idx = 4'd0;
    int          fetch_total = 0;
    logic        done = 1'b0;
    int          error_count = 0;
    int          cycles = 0;
    logic [31:0] exp_fetch_addr;
    logic [31:0] exp_store_addr;
    logic [31:0] exp_store_data;

    // taken beq skips 0x3c, jal skips 0x48, then the self loop at 0x6c
    logic [31:0] fetch_order [32] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c,
        32'h20, 32'h24, 32'h28, 32'h2c, 32'h30, 32'h34, 32'h38, 32'h40,
        32'h44, 32'h4c, 32'h50, 32'h54, 32'h58, 32'h5c, 32'h60, 32'h64,
        32'h68, 32'h6c, 32'h6c, 32'h6c, 32'h6c, 32'h6c, 32'h6c, 32'h6c
    };

    logic [31:0] store_addr_exp [10] = '{
        32'h200, 32'h204, 32'h208, 32'h20c, 32'h210,
        32'h214, 32'h218, 32'h104, 32'h21c, 32'h220
    };

    // 5+12, 5-12, 5&12, 5|12, 5^12, lui, link of jal, loaded+1, x0, -1
    logic [31:0] store_data_exp [10] = '{
        32'h0000_0011, 32'hffff_fff9, 32'h0000_0004, 32'h0000_000d, 32'h0000_0009,
        32'h1234_5000, 32'h0000_0048, 32'h0000_1235, 32'h0000_0000, 32'hffff_ffff
    };

    assign exp_fetch_addr = fetch_order[fetch_idx];
    assign exp_store_addr = store_addr_exp[store_idx];
    assign exp_store_data = store_data_exp[store_idx];

    rv_core #(
        .reset_vector(32'h0),
        .reg_count(32)
    ) rv_core_inst (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .fetch_valid(fetch_valid),
        .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready),
        .fetch_data(fetch_data),
        .mem_valid(mem_valid),
        .mem_write(mem_write),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    initial begin
        forever #20 inst_selfdefine = ~inst_selfdefine;
    end

    // RV32I encodings
    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] unwritten_word(input logic [31:0] addr);
        return ~{addr[15:0], addr[31:16]};
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count++;
        $display("[FAIL] %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    // instruction memory with 0 to 3 cycles of ready delay
    always @(posedge inst_selfdefine) begin
        #2;
        if (reset) begin
            fetch_ready = 1'b0;
        end else if (fetch_valid && !fetch_ready) begin
            if (fetch_wait == 0) begin
                fetch_ready = 1'b1;
                fetch_data = (fetch_addr < 32'h100) ? imem[fetch_addr[7:2]]
                                                    : unwritten_word(fetch_addr);
            end else begin
                fetch_wait = fetch_wait - 1;
            end
        end else begin
            fetch_ready = 1'b0;
            fetch_wait = $urandom_range(3, 0);
        end
    end

    // data memory commits a store when it accepts the request
    always @(posedge inst_selfdefine) begin
        #2;
        if (reset) begin
            mem_ready = 1'b0;
            dmem[32'h100] = 32'h0000_1234;
        end else if (mem_valid && !mem_ready) begin
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                if (mem_write) begin
                    dmem[mem_addr] = mem_wdata;
                end else begin
                    mem_rdata = dmem.exists(mem_addr) ? dmem[mem_addr] : unwritten_word(mem_addr);
                end
            end else begin
                mem_wait = mem_wait - 1;
            end
        end else begin
            mem_ready = 1'b0;
            mem_wait = $urandom_range(3, 0);
        end
    end

    always @(posedge inst_selfdefine) begin
        if (reset) begin
            fetch_idx   <= 5'd0;
            store_idx   <= 4'd0;
            fetch_total <= 0;
            done        <= 1'b0;
        end else begin
            if (fetch_valid && fetch_ready) begin
                fetch_total <= fetch_total + 1;
                if (fetch_idx != 5'd31) begin
                    fetch_idx <= fetch_idx + 5'd1;
                end
                if (fetch_addr == halt_addr) begin
                    done <= 1'b1;
                end
            end
            if (mem_valid && mem_ready && mem_write && store_idx != 4'd15) begin
                store_idx <= store_idx + 4'd1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge inst_selfdefine)
        reset |=> !fetch_valid && !mem_valid)
        else note_failure("a request was raised during or right after reset");

    a_first_fetch: assert property (@(posedge inst_selfdefine)
        $fell(reset) |=> fetch_valid && fetch_addr == 32'h0)
        else note_failure("first fetch after reset missing or not at address 0");

    a_fetch_order: assert property (@(posedge inst_selfdefine) disable iff (reset)
        fetch_valid && fetch_ready |-> fetch_addr == exp_fetch_addr)
        else log_mismatch("fetch_order", $sampled(exp_fetch_addr), $sampled(fetch_addr));

    a_fetch_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr))
        else note_failure("fetch request changed before its handshake");

    a_mem_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && !mem_ready |=>
            mem_valid && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_write))
        else note_failure("data request changed before its handshake");

    a_store_count: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && mem_ready && mem_write |-> store_idx < 4'd10)
        else note_failure("a store appeared beyond the expected list");

    a_store_addr: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && mem_ready && mem_write |-> mem_addr == exp_store_addr)
        else log_mismatch("store_addr", $sampled(exp_store_addr), $sampled(mem_addr));

    a_store_data: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && mem_ready && mem_write |-> mem_wdata == exp_store_data)
        else log_mismatch("store_data", $sampled(exp_store_data), $sampled(mem_wdata));

    a_load_addr: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && mem_ready && !mem_write |-> mem_addr == 32'h100)
        else log_mismatch("load_addr", 32'h100, $sampled(mem_addr));

    initial begin
        void'($urandom(52022));
        for (int i = 0; i < 64; i++) begin
            imem[i] = unwritten_word(i * 4);
        end
        imem[0]  = addi(5'd1, 5'd0, 12'd5);
        imem[1]  = addi(5'd2, 5'd0, 12'd12);
        imem[2]  = alu_rr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        imem[3]  = alu_rr(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
        imem[4]  = alu_rr(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);
        imem[5]  = alu_rr(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);
        imem[6]  = alu_rr(7'h00, 3'b100, 5'd7, 5'd1, 5'd2);
        imem[7]  = lui(5'd8, 20'h12345);
        imem[8]  = sw(5'd3, 5'd0, 12'h200);
        imem[9]  = sw(5'd4, 5'd0, 12'h204);
        imem[10] = sw(5'd5, 5'd0, 12'h208);
        imem[11] = sw(5'd6, 5'd0, 12'h20c);
        imem[12] = sw(5'd7, 5'd0, 12'h210);
        imem[13] = sw(5'd8, 5'd0, 12'h214);
        imem[14] = branch(3'b000, 5'd1, 5'd1, 13'd8);
        // only reached if beq falls through
        imem[15] = sw(5'd1, 5'd0, 12'h300);
        imem[16] = branch(3'b001, 5'd1, 5'd1, 13'd8);
        imem[17] = jal(5'd9, 21'd8);
        imem[18] = sw(5'd2, 5'd0, 12'h304);
        imem[19] = sw(5'd9, 5'd0, 12'h218);
        imem[20] = lw(5'd10, 5'd0, 12'h100);
        imem[21] = addi(5'd10, 5'd10, 12'd1);
        imem[22] = sw(5'd10, 5'd0, 12'h104);
        imem[23] = addi(5'd0, 5'd0, 12'd7);
        imem[24] = sw(5'd0, 5'd0, 12'h21c);
        imem[25] = addi(5'd11, 5'd0, 12'hfff);
        imem[26] = sw(5'd11, 5'd0, 12'h220);
        imem[27] = jal(5'd0, 21'd0);

        repeat (4) @(posedge inst_selfdefine);
        #2;
        reset = 1'b0;

        while (!done && cycles < cycle_limit) begin
            @(posedge inst_selfdefine);
            #1;
            cycles++;
        end

        if (!done) begin
            note_failure("timeout, the halt address was never fetched");
        end
        assert (store_idx == 4'd10)
            else note_failure("not every expected store reached the data port");

        $display("fetches %0d, stores %0d of 10, cycles %0d, errors %0d",
                 fetch_total, store_idx, cycles, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_core_pkg::*;
#(
    parameter addr_t reset_vector = '0,
    parameter int    reg_count    = 32
) (
    input  logic  inst_selfdefine,
    input  logic  reset,
    output logic  fetch_valid,
    output addr_t fetch_addr,
    input  logic  fetch_ready,
    input  inst_t fetch_data,
    output logic  mem_valid,
    output logic  mem_write,
    output addr_t mem_addr,
    output xlen_t mem_wdata,
    input  logic  mem_ready,
    input  xlen_t mem_rdata
);

    addr_t    pc;
    addr_t    next_pc;
    addr_t    link_addr;
    logic     inst_en;
    logic     reg_we_en;
    logic     mem_start;
    logic     mem_done;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    xlen_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     rd_write;
    logic     is_branch;
    logic     branch_ne;
    logic     is_jal;
    logic     is_load;
    logic     is_store;
    logic     is_mem;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    alu_result;
    xlen_t    load_data;

    core_control #(
        .reset_vector(reset_vector)
    ) core_control_inst (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .fetch_ready(fetch_ready),
        .is_mem(is_mem),
        .mem_done(mem_done),
        .next_pc(next_pc),
        .fetch_valid(fetch_valid),
        .fetch_addr(fetch_addr),
        .pc(pc),
        .inst_en(inst_en),
        .reg_we_en(reg_we_en),
        .mem_start(mem_start)
    );

    instr_decode instr_decode_inst (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .inst_en(inst_en),
        .fetch_data(fetch_data),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rd_idx(rd_idx),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .rd_write(rd_write),
        .is_branch(is_branch),
        .branch_ne(branch_ne),
        .is_jal(is_jal),
        .is_load(is_load),
        .is_store(is_store),
        .is_mem(is_mem)
    );

    exec_unit exec_unit_inst (
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm(imm),
        .alu_op(alu_op),
        .use_imm(use_imm),
        .is_branch(is_branch),
        .branch_ne(branch_ne),
        .is_jal(is_jal),
        .alu_result(alu_result),
        .next_pc(next_pc),
        .link_addr(link_addr)
    );

    // retire pulse qualified by the instruction's own write enable
    register_file #(
        .reg_count(reg_count)
    ) register_file_inst (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .we(reg_we_en && rd_write),
        .rd_idx(rd_idx),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .is_jal(is_jal),
        .is_load(is_load),
        .link_addr(link_addr),
        .load_data(load_data),
        .alu_result(alu_result),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    load_store_unit load_store_unit_inst (
        .inst_selfdefine(inst_selfdefine),
        .reset(reset),
        .mem_start(mem_start),
        .is_store(is_store),
        .alu_result(alu_result),
        .rs2_data(rs2_data),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),
        .mem_valid(mem_valid),
        .mem_write(mem_write),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_done(mem_done),
        .load_data(load_data)
    );

endmodule

/* source/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
    import rv_core_pkg::*;
(
    input  logic  inst_selfdefine,
    input  logic  reset,
    input  logic  mem_start,
    input  logic  is_store,
    input  addr_t alu_result,
    input  xlen_t rs2_data,
    input  logic  mem_ready,
    input  xlen_t mem_rdata,
    output logic  mem_valid,
    output logic  mem_write,
    output addr_t mem_addr,
    output xlen_t mem_wdata,
    output logic  mem_done,
    output xlen_t load_data
);

    xlen_t load_q;

    assign mem_done = mem_valid && mem_ready;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
        end else if (mem_start) begin
            mem_valid <= 1'b1;
            mem_write <= is_store;
        end else if (mem_done) begin
            mem_valid <= 1'b0;
        end
    end

    // request payload held until the handshake
    always_ff @(posedge inst_selfdefine) begin
        if (mem_start) begin
            mem_addr  <= alu_result;
            mem_wdata <= rs2_data;
        end
        if (mem_done && !mem_write) begin
            load_q <= mem_rdata;
        end
    end

    // bypass so the write-back lands on the handshake edge itself
    assign load_data = (mem_done && !mem_write) ? mem_rdata : load_q;

    a_addr_aligned: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid |-> mem_addr[1:0] == 2'b00);

    a_req_stable: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && !mem_ready |=> $stable(mem_addr) && $stable(mem_wdata));

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file
    import rv_core_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t rd_idx,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  logic     is_jal,
    input  logic     is_load,
    input  xlen_t    link_addr,
    input  xlen_t    load_data,
    input  xlen_t    alu_result,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data
);

    xlen_t regs [reg_count];
    xlen_t rd_data;

    // write-back source
    assign rd_data = is_jal ? link_addr : (is_load ? load_data : alu_result);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_idx != '0 && int'(rd_idx) < reg_count) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // indices past reg_count read as zero in the reduced configuration
    assign rs1_data = (int'(rs1_idx) < reg_count) ? regs[rs1_idx] : '0;
    assign rs2_data = (int'(rs2_idx) < reg_count) ? regs[rs2_idx] : '0;

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import rv_core_pkg::*;
(
    input  addr_t   pc,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    input  xlen_t   imm,
    input  alu_op_t alu_op,
    input  logic    use_imm,
    input  logic    is_branch,
    input  logic    branch_ne,
    input  logic    is_jal,
    output xlen_t   alu_result,
    output addr_t   next_pc,
    output addr_t   link_addr
);

    xlen_t operand_b;
    logic  rs_equal;
    logic  branch_taken;

    assign operand_b = use_imm ? imm : rs2_data;

    // lw and sw arrive here as add, giving the byte address
    always_comb begin
        case (alu_op)
            alu_add:    alu_result = rs1_data + operand_b;
            alu_sub:    alu_result = rs1_data - operand_b;
            alu_and:    alu_result = rs1_data & operand_b;
            alu_or:     alu_result = rs1_data | operand_b;
            alu_xor:    alu_result = rs1_data ^ operand_b;
            alu_pass_b: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // compare always uses rs2, never the immediate
    assign rs_equal     = (rs1_data == rs2_data);
    assign branch_taken = is_branch && (rs_equal ^ branch_ne);

    assign link_addr = pc + 32'd4;

    // branch and jal targets are both pc relative
    assign next_pc = (is_jal || branch_taken) ? pc + imm : link_addr;

endmodule

/* source/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
    import rv_core_pkg::*;
(
    input  logic     inst_selfdefine,
    input  logic     reset,
    input  logic     inst_en,
    input  inst_t    fetch_data,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output reg_idx_t rd_idx,
    output xlen_t    imm,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output logic     rd_write,
    output logic     is_branch,
    output logic     branch_ne,
    output logic     is_jal,
    output logic     is_load,
    output logic     is_store,
    output logic     is_mem
);

    inst_t      inst_q;
    logic [6:0] opcode;
    logic [2:0] funct3;

    // cleared to an all-zero word, which decodes as a no-op
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            inst_q <= '0;
        end else if (inst_en) begin
            inst_q <= fetch_data;
        end
    end

    assign opcode  = inst_q[6:0];
    assign funct3  = inst_q[14:12];
    assign rd_idx  = inst_q[11:7];
    assign rs1_idx = inst_q[19:15];
    assign rs2_idx = inst_q[24:20];
    assign is_mem  = is_load || is_store;

    always_comb begin
        imm       = '0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        rd_write  = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        case (opcode)
            opc_op_imm, opc_op: begin
                use_imm  = (opcode == opc_op_imm);
                imm      = {{20{inst_q[31]}}, inst_q[31:20]};
                rd_write = 1'b1;
                case (funct3)
                    3'b000: alu_op = (opcode == opc_op && inst_q[30]) ? alu_sub : alu_add;
                    3'b100: alu_op = alu_xor;
                    3'b110: alu_op = alu_or;
                    3'b111: alu_op = alu_and;
                    default: rd_write = 1'b0;
                endcase
            end
            opc_lui: begin
                imm      = {inst_q[31:12], 12'b0};
                use_imm  = 1'b1;
                alu_op   = alu_pass_b;
                rd_write = 1'b1;
            end
            opc_branch: begin
                imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                       inst_q[11:8], 1'b0};
                // beq and bne only
                is_branch = (funct3[2:1] == 2'b00);
                branch_ne = funct3[0];
            end
            opc_jal: begin
                imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                       inst_q[30:21], 1'b0};
                is_jal   = 1'b1;
                rd_write = 1'b1;
            end
            opc_load: begin
                imm      = {{20{inst_q[31]}}, inst_q[31:20]};
                use_imm  = 1'b1;
                is_load  = (funct3 == f3_word);
                rd_write = (funct3 == f3_word);
            end
            opc_store: begin
                imm      = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
                use_imm  = 1'b1;
                is_store = (funct3 == f3_word);
            end
            default: ;
        endcase
    end

endmodule

/* source/core_control.sv */
`timescale 1ns/1ps

module core_control
    import rv_core_pkg::*;
#(
    parameter addr_t reset_vector = '0
) (
    input  logic  inst_selfdefine,
    input  logic  reset,
    input  logic  fetch_ready,
    input  logic  is_mem,
    input  logic  mem_done,
    input  addr_t next_pc,
    output logic  fetch_valid,
    output addr_t fetch_addr,
    output addr_t pc,
    output logic  inst_en,
    output logic  reg_we_en,
    output logic  mem_start
);

    ctrl_state_t state;
    logic        fetch_fire;

    assign fetch_fire = fetch_valid && fetch_ready;
    assign inst_en    = fetch_fire;
    assign fetch_addr = pc;
    assign mem_start  = (state == st_execute) && is_mem;

    // retire either straight from execute or when the data access completes
    assign reg_we_en = ((state == st_execute) && !is_mem) ||
                       ((state == st_mem_wait) && mem_done);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state       <= st_fetch;
            pc          <= reset_vector;
            fetch_valid <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (fetch_fire) begin
                        state       <= st_execute;
                        fetch_valid <= 1'b0;
                    end else begin
                        fetch_valid <= 1'b1;
                    end
                end
                st_execute: begin
                    if (is_mem) begin
                        state <= st_mem_wait;
                    end else begin
                        state       <= st_fetch;
                        pc          <= next_pc;
                        fetch_valid <= 1'b1;
                    end
                end
                st_mem_wait: begin
                    if (mem_done) begin
                        state       <= st_fetch;
                        pc          <= next_pc;
                        fetch_valid <= 1'b1;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // no fetch request may come out of a reset cycle
    a_no_fetch_in_reset: assert property (@(posedge inst_selfdefine) reset |=> !fetch_valid);

    a_execute_one_cycle: assert property (@(posedge inst_selfdefine) disable iff (reset)
        state == st_execute |=> state != st_execute);

endmodule

/* source/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int xlen = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // major opcodes in inst[6:0]
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // only whole-word lw and sw are supported
    localparam logic [2:0] f3_word = 3'b010;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_mem_wait
    } ctrl_state_t;

endpackage
